//--- hw/param_pkg.sv
`default_nettype none

package param_pkg;

  // Parameter buffer geometry.
  localparam int PARAM_DEPTH = 8;
  localparam int PARAM_AW    = 3;
  localparam int DATA_W      = 32;

  // SRAM write strobe values.
  localparam logic WRITE_ENB = 1'b1;
  localparam logic WRITE_DIS = 1'b0;

  // Engine view of a parameter word. Only shift[3:0] is used.
  typedef struct packed {
    logic signed [15:0] bias;
    logic        [7:0]  shift;
    logic signed [7:0]  scale;
  } param_fields_t;

  // Host side sees raw, the requant stage sees fields.
  typedef union packed {
    logic [DATA_W-1:0] raw;
    param_fields_t     fields;
  } param_word_u;

endpackage

`default_nettype wire

//--- hw/host_pkg.sv
`default_nettype none

package host_pkg;

  // Burst length field width.
  localparam int LEN_W = 4;

  // Longest burst, one pass over the buffer.
  localparam int MAX_LEN = 8;

endpackage

`default_nettype wire

//--- hw/param_sram.sv
`timescale 1ns/10ps
`default_nettype none

module param_sram (
  input  wire logic                          clk,
  input  wire logic                          cs_i,
  input  wire logic                          we_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] addr_i,
  input  wire logic [param_pkg::DATA_W-1:0]   wdata_i,
  output logic      [param_pkg::DATA_W-1:0]   rdata_o
);

  import param_pkg::*;

  logic [DATA_W-1:0] mem [PARAM_DEPTH];

  // One access per edge. Read data is held until the next read.
  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (we_i == WRITE_ENB) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/param_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module param_wrapper (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          arhns_i,
  input  wire logic                          awhns_i,
  input  wire logic                          whns_i,
  input  wire logic                          rdfin_i,
  input  wire logic                          wrfin_i,
  input  wire logic                          host_cs_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] host_addr_i,
  input  wire logic [param_pkg::DATA_W-1:0]   host_wdata_i,
  input  wire logic                          eng_cs_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] eng_addr_i,
  output logic                               busy_o,
  output logic      [param_pkg::DATA_W-1:0]   rdata_o
);

  import param_pkg::*;

  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] HOST_RD = 2'd1;
  localparam logic [1:0] HOST_WR = 2'd2;

  logic [1:0]          state;
  logic [1:0]          next_state;
  logic                sram_cs;
  logic                sram_we;
  logic [PARAM_AW-1:0] sram_addr;
  logic [DATA_W-1:0]   sram_wdata;

  param_sram u_param_sram (
    .clk     (clk),
    .cs_i    (sram_cs),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (rdata_o)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= IDLE;
      busy_o <= 1'b0;
    end else begin
      state  <= next_state;
      busy_o <= (next_state != IDLE);
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (arhns_i) begin
          next_state = HOST_RD;
        end else if (awhns_i) begin
          next_state = HOST_WR;
        end
      end
      HOST_RD: if (rdfin_i) next_state = IDLE;
      HOST_WR: if (wrfin_i) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  // Port mux. A host command wins the port in its own cycle.
  always_comb begin
    sram_wdata = host_wdata_i;
    sram_we    = WRITE_DIS;
    if (state == HOST_WR) begin
      sram_cs   = host_cs_i;
      sram_addr = host_addr_i;
      sram_we   = whns_i ? WRITE_ENB : WRITE_DIS;
    end else if (state == HOST_RD || arhns_i || awhns_i) begin
      sram_cs   = host_cs_i;
      sram_addr = host_addr_i;
    end else begin
      sram_cs   = eng_cs_i;
      sram_addr = eng_addr_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/host_port.sv
`timescale 1ns/10ps
`default_nettype none

module host_port (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          host_rd_i,
  input  wire logic                          host_wr_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] host_addr_i,
  input  wire logic [host_pkg::LEN_W-1:0]     host_len_i,
  input  wire logic                          host_wvalid_i,
  input  wire logic [param_pkg::DATA_W-1:0]   host_wdata_i,
  input  wire logic                          busy_i,
  input  wire logic [param_pkg::DATA_W-1:0]   rdata_i,
  output logic                               arhns_o,
  output logic                               awhns_o,
  output logic                               whns_o,
  output logic                               rdfin_o,
  output logic                               wrfin_o,
  output logic                               host_cs_o,
  output logic      [param_pkg::PARAM_AW-1:0] beat_addr_o,
  output logic      [param_pkg::DATA_W-1:0]   host_wdata_o,
  output logic                               host_rvalid_o,
  output logic      [param_pkg::DATA_W-1:0]   host_rdata_o,
  output logic                               host_done_o
);

  import param_pkg::*;
  import host_pkg::*;

  logic                rd_active;
  logic                wr_active;
  logic [LEN_W-1:0]    beat_cnt;
  logic [LEN_W-1:0]    len_eff;
  logic [PARAM_AW-1:0] addr_q;
  logic                rvalid_q;
  logic                rd_last_q;
  logic                wr_done_q;
  logic                last_beat;

  // Commands only start from an idle buffer. Read wins a tie.
  assign arhns_o = host_rd_i & ~busy_i;
  assign awhns_o = host_wr_i & ~busy_i & ~host_rd_i;

  // Zero-length and oversized bursts are clamped.
  always_comb begin
    if (host_len_i == '0) begin
      len_eff = LEN_W'(1);
    end else if (host_len_i > LEN_W'(MAX_LEN)) begin
      len_eff = LEN_W'(MAX_LEN);
    end else begin
      len_eff = host_len_i;
    end
  end

  assign last_beat    = (beat_cnt == LEN_W'(1));
  assign whns_o       = host_wvalid_i & wr_active;
  assign host_cs_o    = rd_active | whns_o;
  assign beat_addr_o  = addr_q;
  assign host_wdata_o = host_wdata_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_active <= 1'b0;
      wr_active <= 1'b0;
      beat_cnt  <= '0;
      addr_q    <= '0;
      rvalid_q  <= 1'b0;
      rd_last_q <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      // Read data lags the SRAM access by one cycle.
      rvalid_q  <= rd_active;
      rd_last_q <= rd_active & last_beat;
      wr_done_q <= 1'b0;
      if (arhns_o) begin
        rd_active <= 1'b1;
        addr_q    <= host_addr_i;
        beat_cnt  <= len_eff;
      end else if (awhns_o) begin
        wr_active <= 1'b1;
        addr_q    <= host_addr_i;
        beat_cnt  <= len_eff;
      end else if (rd_active || whns_o) begin
        addr_q   <= addr_q + 1'b1;
        beat_cnt <= beat_cnt - 1'b1;
        if (last_beat) begin
          rd_active <= 1'b0;
          wr_active <= 1'b0;
          wr_done_q <= wr_active;
        end
      end
    end
  end

  assign host_rvalid_o = rvalid_q;
  assign host_rdata_o  = rdata_i;
  assign rdfin_o       = rd_last_q;
  assign wrfin_o       = wr_done_q;
  assign host_done_o   = rd_last_q | wr_done_q;

endmodule

`default_nettype wire

//--- hw/requant_unit.sv
`timescale 1ns/10ps
`default_nettype none

module requant_unit #(
  parameter int SAMPLE_W = 16
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          sample_valid_i,
  input  wire logic signed [SAMPLE_W-1:0]    sample_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] channel_i,
  input  wire param_pkg::param_word_u        param_i,
  output logic                               eng_cs_o,
  output logic      [param_pkg::PARAM_AW-1:0] eng_addr_o,
  output logic                               result_valid_o,
  output logic      [param_pkg::DATA_W-1:0]   result_o
);

  import param_pkg::*;

  logic                       s1_valid;
  logic signed [SAMPLE_W-1:0] s1_sample;
  logic signed [DATA_W-1:0]   product;
  logic signed [DATA_W-1:0]   shifted;
  logic signed [DATA_W-1:0]   bias_ext;
  logic signed [DATA_W-1:0]   sum;

  // Stage 1. Lookup goes out with the sample.
  assign eng_cs_o   = sample_valid_i;
  assign eng_addr_o = channel_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid       <= 1'b0;
      result_valid_o <= 1'b0;
    end else begin
      s1_valid       <= sample_valid_i;
      result_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_sample <= sample_i;
  end

  // Stage 2. Parameter word arrives from the SRAM here.
  always_comb begin
    product  = DATA_W'(s1_sample) * DATA_W'($signed(param_i.fields.scale));
    shifted  = product >>> param_i.fields.shift[3:0];
    bias_ext = DATA_W'($signed(param_i.fields.bias));
    sum      = shifted + bias_ext;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result_o <= sum;
    end
  end

endmodule

`default_nettype wire

//--- hw/conv_param_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_param_top #(
  parameter int SAMPLE_W = 16
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          host_rd_i,
  input  wire logic                          host_wr_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] host_addr_i,
  input  wire logic [host_pkg::LEN_W-1:0]     host_len_i,
  input  wire logic                          host_wvalid_i,
  input  wire logic [param_pkg::DATA_W-1:0]   host_wdata_i,
  input  wire logic                          sample_valid_i,
  input  wire logic signed [SAMPLE_W-1:0]    sample_i,
  input  wire logic [param_pkg::PARAM_AW-1:0] channel_i,
  output logic                               host_rvalid_o,
  output logic      [param_pkg::DATA_W-1:0]   host_rdata_o,
  output logic                               host_done_o,
  output logic                               busy_o,
  output logic                               result_valid_o,
  output logic      [param_pkg::DATA_W-1:0]   result_o
);

  import param_pkg::*;

  logic                arhns;
  logic                awhns;
  logic                whns;
  logic                rdfin;
  logic                wrfin;
  logic                host_cs;
  logic [PARAM_AW-1:0] host_beat_addr;
  logic [DATA_W-1:0]   host_wdata;
  logic                eng_cs;
  logic [PARAM_AW-1:0] eng_addr;
  logic [DATA_W-1:0]   rdata;

  host_port u_host_port (
    .clk           (clk),
    .rst           (rst),
    .host_rd_i     (host_rd_i),
    .host_wr_i     (host_wr_i),
    .host_addr_i   (host_addr_i),
    .host_len_i    (host_len_i),
    .host_wvalid_i (host_wvalid_i),
    .host_wdata_i  (host_wdata_i),
    .busy_i        (busy_o),
    .rdata_i       (rdata),
    .arhns_o       (arhns),
    .awhns_o       (awhns),
    .whns_o        (whns),
    .rdfin_o       (rdfin),
    .wrfin_o       (wrfin),
    .host_cs_o     (host_cs),
    .beat_addr_o   (host_beat_addr),
    .host_wdata_o  (host_wdata),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_done_o   (host_done_o)
  );

  param_wrapper u_param_wrapper (
    .clk          (clk),
    .rst          (rst),
    .arhns_i      (arhns),
    .awhns_i      (awhns),
    .whns_i       (whns),
    .rdfin_i      (rdfin),
    .wrfin_i      (wrfin),
    .host_cs_i    (host_cs),
    .host_addr_i  (host_beat_addr),
    .host_wdata_i (host_wdata),
    .eng_cs_i     (eng_cs),
    .eng_addr_i   (eng_addr),
    .busy_o       (busy_o),
    .rdata_o      (rdata)
  );

  requant_unit #(
    .SAMPLE_W (SAMPLE_W)
  ) u_requant_unit (
    .clk            (clk),
    .rst            (rst),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .channel_i      (channel_i),
    .param_i        (rdata),
    .eng_cs_o       (eng_cs),
    .eng_addr_o     (eng_addr),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

//--- sim/conv_param_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module conv_param_asserts (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic [1:0] state_i,
  input wire logic       busy_i,
  input wire logic       arhns_i,
  input wire logic       whns_i,
  input wire logic       rdfin_i
);

  import host_pkg::*;

  // Same encoding as the wrapper FSM.
  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] HOST_RD = 2'd1;

  int unsigned rd_cycles;

  // Cycles since a read command while the host still owns the port.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_cycles <= 0;
    end else if (arhns_i) begin
      rd_cycles <= 1;
    end else if (rd_cycles != 0 && state_i != IDLE) begin
      rd_cycles <= rd_cycles + 1;
    end else begin
      rd_cycles <= 0;
    end
  end

  a_busy_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy_i)
    else $error("busy set right after reset");
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst)
    state_i == HOST_RD |-> !whns_i)
    else $error("write beat while the wrapper is in the read state");
  a_rdfin_in_read: assert property (@(posedge clk) disable iff (rst)
    rdfin_i |-> state_i == HOST_RD)
    else $error("rdfin outside the read state");
  a_read_returns_idle: assert property (@(posedge clk) disable iff (rst)
    rd_cycles <= MAX_LEN + 2)
    else $error("read burst held the port too long");

endmodule

bind param_wrapper conv_param_asserts u_conv_param_asserts (
  .clk     (clk),
  .rst     (rst),
  .state_i (state),
  .busy_i  (busy_o),
  .arhns_i (arhns_i),
  .whns_i  (whns_i),
  .rdfin_i (rdfin_i)
);

`default_nettype wire

//--- sim/tb_conv_param.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_param;

  import param_pkg::*;
  import host_pkg::*;

  localparam int SAMPLE_W   = 16;
  localparam int CLK_PERIOD = 8;
  localparam int NROWS      = 18;
  localparam int WAIT_LIMIT = 16;
  localparam logic [1:0] OP_WR  = 2'd0;
  localparam logic [1:0] OP_RD  = 2'd1;
  localparam logic [1:0] OP_SMP = 2'd2;

  logic clk, rst;
  logic host_rd_i, host_wr_i, host_wvalid_i, sample_valid_i;
  logic host_rvalid_o, host_done_o, busy_o, result_valid_o;
  logic [PARAM_AW-1:0] host_addr_i, channel_i;
  logic [LEN_W-1:0] host_len_i;
  logic [DATA_W-1:0] host_wdata_i, host_rdata_o, result_o;
  logic signed [SAMPLE_W-1:0] sample_i;

  // Operation table. Sample rows alternate between channel addr and addr+1.
  logic [1:0]          op_tab   [NROWS];
  string               name_tab [NROWS];
  logic [PARAM_AW-1:0] addr_tab [NROWS];
  int                  len_tab  [NROWS];
  logic [DATA_W-1:0]   data_tab [NROWS][MAX_LEN];
  logic [DATA_W-1:0]   exp_tab  [NROWS][MAX_LEN];
  logic [DATA_W-1:0]   shadow   [PARAM_DEPTH];
  int nrow   = 0;
  int errors = 0;
  int checks = 0;
  int seed   = 32'h17fa;

  conv_param_top #(.SAMPLE_W(SAMPLE_W)) u_conv_param_top (.*);

  // ((sample * scale) >>> shift[3:0]) + bias, all signed.
  function automatic logic [DATA_W-1:0] requant_ref(input logic [DATA_W-1:0] word,
                                                    input logic [SAMPLE_W-1:0] smp);
    int prod;
    prod = int'($signed(smp)) * int'($signed(word[7:0]));
    return DATA_W'((prod >>> word[11:8]) + int'($signed(word[31:16])));
  endfunction

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp_val,
                            input logic [DATA_W-1:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      errors++;
      $display("Error: %s expected %h actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic add_row(input logic [1:0] op, input string name, input int addr,
                         input int len);
    logic [DATA_W-1:0] w;
    int a;
    op_tab[nrow]   = op;
    name_tab[nrow] = name;
    addr_tab[nrow] = PARAM_AW'(addr);
    len_tab[nrow]  = len;
    for (int k = 0; k < len; k++) begin
      a = (op == OP_SMP) ? (addr + k % 2) % PARAM_DEPTH : (addr + k) % PARAM_DEPTH;
      w = $random(seed);
      if (op == OP_WR) begin
        // Shift 0 on channel 0, shift 15 on channel 1, negative scale on channel 2.
        if (a == 0) w[11:8] = 4'd0;
        if (a == 1) w[11:8] = 4'd15;
        if (a == 2) w[7] = 1'b1;
        shadow[a] = w;
      end else if (op == OP_SMP && a == 3) begin
        w[SAMPLE_W-1] = 1'b1;
      end
      data_tab[nrow][k] = w;
      exp_tab[nrow][k]  = (op == OP_RD) ? shadow[a] : requant_ref(shadow[a], w[SAMPLE_W-1:0]);
    end
    nrow++;
  endtask

  task automatic run_write(input int r);
    @(negedge clk);
    host_wr_i   = 1'b1;
    host_addr_i = addr_tab[r];
    host_len_i  = LEN_W'(len_tab[r]);
    @(negedge clk);
    host_wr_i = 1'b0;
    for (int k = 0; k < len_tab[r]; k++) begin
      // Short bursts leave an idle cycle between beats.
      if (k > 0 && len_tab[r] < MAX_LEN) @(negedge clk);
      check_word({name_tab[r], " busy"}, DATA_W'(1), DATA_W'(busy_o));
      host_wvalid_i = 1'b1;
      host_wdata_i  = data_tab[r][k];
      @(negedge clk);
      host_wvalid_i = 1'b0;
    end
    check_word({name_tab[r], " done"}, DATA_W'(1), DATA_W'(host_done_o));
    @(negedge clk);
    check_word({name_tab[r], " busy"}, DATA_W'(0), DATA_W'(busy_o));
  endtask

  // Read beats and results both show up two cycles after their request.
  task automatic run_stream(input int r);
    int cyc;
    int k_in;
    int k_out;
    bit is_rd;
    is_rd = (op_tab[r] == OP_RD);
    cyc   = 0;
    k_in  = 0;
    k_out = 0;
    @(negedge clk);
    host_rd_i   = is_rd;
    host_addr_i = addr_tab[r];
    host_len_i  = LEN_W'(len_tab[r]);
    while (k_out < len_tab[r] && cyc < WAIT_LIMIT) begin
      sample_valid_i = 1'b0;
      if (!is_rd && k_in < len_tab[r]) begin
        sample_valid_i = 1'b1;
        sample_i       = data_tab[r][k_in][SAMPLE_W-1:0];
        channel_i      = addr_tab[r] + PARAM_AW'(k_in % 2);
        k_in++;
      end
      @(negedge clk);
      host_rd_i = 1'b0;
      cyc++;
      if (is_rd ? host_rvalid_o : result_valid_o) begin
        check_word({name_tab[r], " cycle"}, DATA_W'(k_out + 2), DATA_W'(cyc));
        check_word(name_tab[r], exp_tab[r][k_out], is_rd ? host_rdata_o : result_o);
        if (is_rd) begin
          check_word({name_tab[r], " done"}, DATA_W'(k_out == len_tab[r] - 1),
                     DATA_W'(host_done_o));
        end
        k_out++;
      end
    end
    sample_valid_i = 1'b0;
    check_word({name_tab[r], " count"}, DATA_W'(len_tab[r]), DATA_W'(k_out));
    @(negedge clk);
    check_word({name_tab[r], " busy"}, DATA_W'(0), DATA_W'(busy_o));
    check_word({name_tab[r], " valid"}, DATA_W'(0),
               DATA_W'(is_rd ? host_rvalid_o : result_valid_o));
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Budget of 20 cycles per table row plus reset and margin.
  initial begin
    #(CLK_PERIOD * (20 * NROWS + 100));
    $display("Watchdog expired before the test sequence finished");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    rst            = 1'b1;
    host_rd_i      = 1'b0;
    host_wr_i      = 1'b0;
    host_addr_i    = '0;
    host_len_i     = '0;
    host_wvalid_i  = 1'b0;
    host_wdata_i   = '0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    channel_i      = '0;
    add_row(OP_WR, "full_write", 0, 8);
    add_row(OP_RD, "full_read", 0, 8);
    add_row(OP_WR, "wrap_write", 6, 3);
    add_row(OP_RD, "wrap_read", 0, 8);
    for (int c = 0; c < PARAM_DEPTH; c++) begin
      add_row(OP_SMP, "single_sample", c, 1);
    end
    add_row(OP_SMP, "b2b_stream", 1, 8);
    add_row(OP_SMP, "b2b_stream", 6, 6);
    add_row(OP_WR, "update_write", 5, 1);
    add_row(OP_SMP, "update_sample", 5, 1);
    add_row(OP_SMP, "update_stream", 4, 4);
    add_row(OP_RD, "update_read", 4, 2);
    repeat (5) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NROWS; r++) begin
      if (op_tab[r] == OP_WR) begin
        run_write(r);
      end else begin
        run_stream(r);
      end
    end
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/param_pkg.sv
hw/host_pkg.sv
hw/param_sram.sv
hw/param_wrapper.sv
hw/host_port.sv
hw/requant_unit.sv
hw/conv_param_top.sv
sim/conv_param_asserts.sv
sim/tb_conv_param.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_conv_param -f sources.f -o sim_conv_param
./obj_dir/sim_conv_param | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
